//--- verilog/cam_cfg_pkg.sv
package cam_cfg_pkg;

    // Sensor register map widths
    typedef logic [15:0] reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [7:0]  i2c_byte_t;
    typedef logic [7:0]  entry_idx_t;

    // Command flags that go with every byte handed to the I2C master
    typedef struct packed {
        logic start;  // Generate START before the byte
        logic stop;   // Generate STOP after the byte
        logic write;  // Byte is transmitted, not read
    } i2c_cmd_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
        logic      last;  // Final entry of the walk
    } reg_write_t;

    // Byte position inside one four-byte write
    typedef enum logic [1:0] {
        PH_DEV     = 2'd0,
        PH_ADDR_HI = 2'd1,
        PH_ADDR_LO = 2'd2,
        PH_DATA    = 2'd3
    } byte_phase_t;

    typedef enum logic [1:0] {
        ST_POWERUP = 2'd0,
        ST_ISSUE   = 2'd1,
        ST_DONE    = 2'd2
    } walk_state_t;

    // 7-bit address 0x3c shifted left with the R/W bit clear
    localparam i2c_byte_t DEV_WRITE_ADDR = 8'h78;

    localparam int TABLE_DEPTH = 16;  // Entries held in the lookup

endpackage

//--- verilog/cam_cfg_index.sv
`timescale 1ns/1ps

module cam_cfg_index #(
    parameter int POWERUP_CYCLES = 1000000,
    parameter int REG_COUNT      = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    idx_valid,
    output cam_cfg_pkg::entry_idx_t idx,
    output logic                    idx_last,
    input  logic                    idx_ready
);
    import cam_cfg_pkg::*;

    localparam int         CNT_W    = $clog2(POWERUP_CYCLES + 1);
    localparam entry_idx_t LAST_IDX = entry_idx_t'(REG_COUNT - 1);

    walk_state_t      state;
    logic [CNT_W-1:0] wait_cnt;  // Power-up delay counter
    logic             idx_fire;

    assign idx_valid = (state == ST_ISSUE);
    assign idx_last  = (idx == LAST_IDX);
    assign idx_fire  = idx_valid && idx_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_POWERUP;
            wait_cnt <= '0;
            idx      <= '0;
        end else begin
            case (state)
                ST_POWERUP: begin
                    // Leave on the POWERUP_CYCLES-th edge after reset release
                    if (wait_cnt == CNT_W'(POWERUP_CYCLES - 1)) begin
                        state <= ST_ISSUE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_ISSUE: begin
                    if (idx_fire) begin
                        if (idx_last) begin
                            state <= ST_DONE;  // Whole table handed over
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_DONE;  // Idle until the next reset
                end
                default: begin
                    state <= ST_POWERUP;
                end
            endcase
        end
    end

    // Walk must stop at the last programmed register
    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        idx_valid |-> (int'(idx) < REG_COUNT)
    ) else $error("index walked past REG_COUNT");

endmodule

//--- verilog/cam_cfg_table.sv
`timescale 1ns/1ps

module cam_cfg_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    idx_valid,
    input  cam_cfg_pkg::entry_idx_t idx,
    input  logic                    idx_last,
    output logic                    idx_ready,
    output logic                    entry_valid,
    output cam_cfg_pkg::reg_write_t entry,
    input  logic                    entry_ready
);
    import cam_cfg_pkg::*;

    reg_write_t lut_entry;   // Lookup result for the offered index
    reg_write_t hold_entry;  // Second slot while the serializer stalls
    logic       hold_valid;
    logic       in_fire;
    logic       out_free;

    assign idx_ready = !hold_valid;  // Registered only, no path from idx_valid
    assign in_fire   = idx_valid && idx_ready;
    assign out_free  = !entry_valid || entry_ready;

    // Start of the sensor bring-up sequence
    always_comb begin
        lut_entry.last = idx_last;
        case (idx)
            8'd0:    {lut_entry.addr, lut_entry.data} = {16'h3103, 8'h11};  // Clock from pad
            8'd1:    {lut_entry.addr, lut_entry.data} = {16'h3008, 8'h82};  // Soft reset
            8'd2:    {lut_entry.addr, lut_entry.data} = {16'h3008, 8'h42};  // Soft power down
            8'd3:    {lut_entry.addr, lut_entry.data} = {16'h3103, 8'h03};  // Clock from PLL
            8'd4:    {lut_entry.addr, lut_entry.data} = {16'h3017, 8'hff};  // Pad output enables
            8'd5:    {lut_entry.addr, lut_entry.data} = {16'h3018, 8'hff};
            8'd6:    {lut_entry.addr, lut_entry.data} = {16'h3034, 8'h1a};
            8'd7:    {lut_entry.addr, lut_entry.data} = {16'h3037, 8'h13};  // PLL dividers
            8'd8:    {lut_entry.addr, lut_entry.data} = {16'h3108, 8'h01};
            8'd9:    {lut_entry.addr, lut_entry.data} = {16'h3630, 8'h36};
            8'd10:   {lut_entry.addr, lut_entry.data} = {16'h3631, 8'h0e};
            8'd11:   {lut_entry.addr, lut_entry.data} = {16'h3632, 8'he2};
            8'd12:   {lut_entry.addr, lut_entry.data} = {16'h3633, 8'h12};
            8'd13:   {lut_entry.addr, lut_entry.data} = {16'h3621, 8'he0};
            8'd14:   {lut_entry.addr, lut_entry.data} = {16'h3704, 8'ha0};
            8'd15:   {lut_entry.addr, lut_entry.data} = {16'h3703, 8'h5a};
            default: {lut_entry.addr, lut_entry.data} = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= 1'b0;
            hold_valid  <= 1'b0;
        end else if (out_free) begin
            // Output slot refills from the holding slot first
            entry_valid <= hold_valid || in_fire;
            hold_valid  <= 1'b0;
        end else if (in_fire) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            entry <= hold_valid ? hold_entry : lut_entry;
        end else if (in_fire) begin
            hold_entry <= lut_entry;
        end
    end

    a_entry_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (entry_valid && !entry_ready) |=> (entry_valid && $stable(entry))
    ) else $error("entry changed while stalled");

endmodule

//--- verilog/cam_cfg_serializer.sv
`timescale 1ns/1ps

module cam_cfg_serializer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    entry_valid,
    input  cam_cfg_pkg::reg_write_t entry,
    output logic                    entry_ready,
    output logic                    cmd_valid,
    output cam_cfg_pkg::i2c_cmd_t   cmd,
    output cam_cfg_pkg::i2c_byte_t  cmd_byte,
    input  logic                    cmd_ready,
    output logic                    config_done
);
    import cam_cfg_pkg::*;

    localparam i2c_cmd_t CMD_FIRST = '{start: 1'b1, stop: 1'b0, write: 1'b1};
    localparam i2c_cmd_t CMD_MID   = '{start: 1'b0, stop: 1'b0, write: 1'b1};
    localparam i2c_cmd_t CMD_LAST  = '{start: 1'b0, stop: 1'b1, write: 1'b1};
    localparam i2c_cmd_t CMD_IDLE  = '{start: 1'b0, stop: 1'b0, write: 1'b0};

    byte_phase_t phase;       // Byte currently offered
    reg_write_t  cur;         // Entry being framed
    logic        entry_fire;
    logic        cmd_fire;

    // Free only between transactions
    assign entry_ready = (phase == PH_DEV) && !cmd_valid && !config_done;
    assign entry_fire  = entry_valid && entry_ready;
    assign cmd_fire    = cmd_valid && cmd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= PH_DEV;
            cmd_valid   <= 1'b0;
            config_done <= 1'b0;
        end else if (entry_fire) begin
            cmd_valid <= 1'b1;  // Device address goes out first
        end else if (cmd_fire) begin
            case (phase)
                PH_DEV:     phase <= PH_ADDR_HI;
                PH_ADDR_HI: phase <= PH_ADDR_LO;
                PH_ADDR_LO: phase <= PH_DATA;
                default: begin
                    // Stop byte taken, transaction closed
                    phase       <= PH_DEV;
                    cmd_valid   <= 1'b0;
                    config_done <= config_done || cur.last;
                end
            endcase
        end
    end

    // Byte and flags for the next phase, loaded as the current one is taken
    always_ff @(posedge clk) begin
        if (entry_fire) begin
            cur      <= entry;
            cmd      <= CMD_FIRST;
            cmd_byte <= DEV_WRITE_ADDR;
        end else if (cmd_fire) begin
            case (phase)
                PH_DEV: begin
                    cmd      <= CMD_MID;
                    cmd_byte <= cur.addr[15:8];
                end
                PH_ADDR_HI: begin
                    cmd_byte <= cur.addr[7:0];
                end
                PH_ADDR_LO: begin
                    cmd      <= CMD_LAST;
                    cmd_byte <= cur.data;
                end
                default: begin
                    cmd <= CMD_IDLE;
                end
            endcase
        end
    end

    // Nothing may reach the bus once the table is finished
    a_quiet_after_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        config_done |-> !$rose(cmd_valid)
    ) else $error("command issued after config_done");

endmodule

//--- verilog/cam_cfg_top.sv
`timescale 1ns/1ps

module cam_cfg_top #(
    parameter int POWERUP_CYCLES = 1000000,  // 20 ms at 50 MHz
    parameter int REG_COUNT      = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   cmd_valid,
    output cam_cfg_pkg::i2c_cmd_t  cmd,
    output cam_cfg_pkg::i2c_byte_t cmd_byte,
    input  logic                   cmd_ready,
    output logic                   config_done
);
    import cam_cfg_pkg::*;

    logic       idx_valid;
    entry_idx_t idx;
    logic       idx_last;
    logic       idx_ready;
    logic       entry_valid;
    reg_write_t entry;
    logic       entry_ready;

    if (REG_COUNT > TABLE_DEPTH) begin : g_count_check
        $error("REG_COUNT larger than the register table");
    end

    cam_cfg_index #(
        .POWERUP_CYCLES (POWERUP_CYCLES),
        .REG_COUNT      (REG_COUNT)
    ) u_index (
        .clk       (clk),
        .rst_n     (rst_n),
        .idx_valid (idx_valid),
        .idx       (idx),
        .idx_last  (idx_last),
        .idx_ready (idx_ready)
    );

    cam_cfg_table u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .idx_valid   (idx_valid),
        .idx         (idx),
        .idx_last    (idx_last),
        .idx_ready   (idx_ready),
        .entry_valid (entry_valid),
        .entry       (entry),
        .entry_ready (entry_ready)
    );

    cam_cfg_serializer u_serializer (
        .clk         (clk),
        .rst_n       (rst_n),
        .entry_valid (entry_valid),
        .entry       (entry),
        .entry_ready (entry_ready),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_byte    (cmd_byte),
        .cmd_ready   (cmd_ready),
        .config_done (config_done)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;  // Released away from the active edge
    end

endmodule

//--- sim/tb_cam_cfg.sv
`timescale 1ns/1ps

module tb_cam_cfg;
    import cam_cfg_pkg::*;

    localparam int        POWERUP   = 20;
    localparam int        REG_COUNT = 16;
    localparam int        N_BYTES   = 4 * REG_COUNT;
    localparam int        TIMEOUT   = 2000;
    localparam i2c_byte_t EXP_DEV   = 8'h78;  // Sensor write address

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    i2c_cmd_t  cmd;
    i2c_byte_t cmd_byte;
    logic      cmd_ready;
    logic      config_done;

    logic [23:0] ref_words [REG_COUNT];  // Register address then data
    i2c_cmd_t    exp_cmd   [N_BYTES];
    i2c_byte_t   exp_byte  [N_BYTES];

    // Master model state updated once per falling edge
    logic        accepted;
    logic        stalled;
    i2c_cmd_t    held_cmd;
    i2c_byte_t   held_byte;

    tb_clock_gen #(.PERIOD_NS(10.0), .RESET_CYCLES(16)) u_clk (.clk(clk), .rst_n(rst_n));

    cam_cfg_top #(
        .POWERUP_CYCLES (POWERUP),
        .REG_COUNT      (REG_COUNT)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_byte    (cmd_byte),
        .cmd_ready   (cmd_ready),
        .config_done (config_done)
    );

    task automatic check_cmd(input string name, input i2c_cmd_t exp, input i2c_cmd_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on timeout");
    endtask

    task automatic load_register_table();
        ref_words[0]  = 24'h3103_11;
        ref_words[1]  = 24'h3008_82;
        ref_words[2]  = 24'h3008_42;
        ref_words[3]  = 24'h3103_03;
        ref_words[4]  = 24'h3017_ff;
        ref_words[5]  = 24'h3018_ff;
        ref_words[6]  = 24'h3034_1a;
        ref_words[7]  = 24'h3037_13;
        ref_words[8]  = 24'h3108_01;
        ref_words[9]  = 24'h3630_36;
        ref_words[10] = 24'h3631_0e;
        ref_words[11] = 24'h3632_e2;
        ref_words[12] = 24'h3633_12;
        ref_words[13] = 24'h3621_e0;
        ref_words[14] = 24'h3704_a0;
        ref_words[15] = 24'h3703_5a;
    endtask

    // Four bytes per register write with flags by position in the group
    task automatic build_expected();
        reg_addr_t addr;
        reg_data_t data;
        for (int e = 0; e < REG_COUNT; e++) begin
            {addr, data}    = ref_words[e];
            exp_byte[4*e]   = EXP_DEV;
            exp_byte[4*e+1] = addr[15:8];
            exp_byte[4*e+2] = addr[7:0];
            exp_byte[4*e+3] = data;
        end
        for (int k = 0; k < N_BYTES; k++) begin
            exp_cmd[k].start = (k % 4 == 0);
            exp_cmd[k].stop  = (k % 4 == 3);
            exp_cmd[k].write = 1'b1;
        end
    endtask

    // One falling edge of the I2C master model with random stalls
    task automatic step_master();
        logic ready_now;
        @(negedge clk);
        if (stalled) begin
            check_bit("valid held under stall", 1'b1, cmd_valid);
            check_cmd("cmd held under stall", held_cmd, cmd);
            check_byte("byte held under stall", held_byte, cmd_byte);
        end
        ready_now = (($urandom % 4) != 0);
        cmd_ready <= ready_now;
        accepted  = cmd_valid && ready_now;  // Taken on the next rising edge
        stalled   = cmd_valid && !ready_now;
        held_cmd  = cmd;
        held_byte = cmd_byte;
    endtask

    initial begin
        int wait_cycles;
        cmd_ready = 1'b0;
        accepted  = 1'b0;
        stalled   = 1'b0;
        void'($urandom(70));
        load_register_table();
        build_expected();

        wait_cycles = 0;
        while (rst_n !== 1'b1) begin
            step_master();
            wait_cycles++;
            if (wait_cycles >= TIMEOUT) report_timeout("reset release");
        end

        for (int c = 0; c < POWERUP; c++) begin
            step_master();
            check_bit($sformatf("cmd_valid in power-up cycle %0d", c), 1'b0, cmd_valid);
            check_bit($sformatf("config_done in power-up cycle %0d", c), 1'b0, config_done);
        end

        for (int i = 0; i < N_BYTES; i++) begin
            wait_cycles = 0;
            accepted    = 1'b0;
            while (!accepted) begin
                step_master();
                check_bit($sformatf("config_done before byte %0d", i), 1'b0, config_done);
                wait_cycles++;
                if (!accepted && wait_cycles >= TIMEOUT) begin
                    report_timeout($sformatf("byte %0d to be accepted", i));
                end
            end
            check_cmd($sformatf("flags of byte %0d", i), exp_cmd[i], cmd);
            check_byte($sformatf("value of byte %0d", i), exp_byte[i], cmd_byte);
        end

        step_master();
        check_bit("config_done after last stop byte", 1'b1, config_done);
        for (int c = 0; c < 50; c++) begin
            step_master();
            check_bit($sformatf("cmd_valid idle %0d after done", c), 1'b0, cmd_valid);
            check_bit($sformatf("config_done held %0d", c), 1'b1, config_done);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- cam_cfg_top.f
verilog/cam_cfg_pkg.sv
verilog/cam_cfg_index.sv
verilog/cam_cfg_table.sv
verilog/cam_cfg_serializer.sv
verilog/cam_cfg_top.sv
sim/tb_clock_gen.sv
sim/tb_cam_cfg.sv

//--- Bender.yml
package:
  name: cam_cfg

sources:
  - files:
      - verilog/cam_cfg_pkg.sv
      - verilog/cam_cfg_index.sv
      - verilog/cam_cfg_table.sv
      - verilog/cam_cfg_serializer.sv
      - verilog/cam_cfg_top.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_cam_cfg.sv
